//--- hdl/amigaBus_settings.svh
////////////////////
// Cycle timing and overlay register settings for the bus decoder
// Include this header in any module that needs the per-region wait counts
// or the CIA-A register that holds the ROM overlay bit
////////////////////

`ifndef AMIGABUS_SETTINGS_SVH
`define AMIGABUS_SETTINGS_SVH

////////////////////
// Region wait counts
////////////////////

// Cycles from the first strobe edge to ta for a Kickstart ROM access
`define ROM_WAIT 2

// Cycles from the first strobe edge to ta for either CIA
`define CIA_WAIT 4

// Interrupt acknowledge cycles are ended almost at once by autovectoring
`define AUTOVECTOR_WAIT 1

// Cycles before tea ends an access that decodes to no region
`define ERROR_WAIT 3

////////////////////
// Overlay register
////////////////////

// CIA-A register number (A[11:8]) whose data bit 0 drives the overlay
`define OVL_REG_OFFSET 0

`endif

//--- hdl/amigaBusPkg.sv
////////////////////
// Shared types of the bus decoder
// Address, transfer attribute and data vectors, the region flag struct
// and the cycle FSM states, all used by scoped name
////////////////////

`default_nettype none

package amigaBusPkg;

    ////////////////////
    // Bus vectors
    ////////////////////

    // Address lines A[31:1], bit numbering follows the processor pins
    typedef logic [31:1] addrT;

    // Transfer type, the value 3 is an interrupt acknowledge
    typedef logic [1:0] ttT;

    // Transfer modifier, 1 is data and 2 is code
    typedef logic [1:0] tmT;

    // Low byte of the data bus as written to a CIA
    typedef logic [7:0] byteT;

    // Wide enough for the longest fixed wait of any region
    typedef logic [2:0] waitCntT;

    ////////////////////
    // Region decode
    ////////////////////

    // Active-high region flags out of the decoder
    // Only the two CIA flags may be set at the same time
    typedef struct packed {
        logic rom;
        logic ciaA;
        logic ciaB;
        logic chipRam;
        logic chipReg;
        logic autovector;
    } decodeT;

    // States of the per-cycle controller
    typedef enum logic [1:0] {
        idle,
        waitFixed,
        waitAgnus,
        finish
    } cycleStateT;

endpackage

`default_nettype wire

//--- hdl/addressDecode.sv
////////////////////
// Combinational region decode of a 68040 bus transfer
// Takes the address, transfer type, transfer modifier and overlay bit
// and raises one flag per selected region
////////////////////

`timescale 1ns/1ps
`default_nettype none

module addressDecode (
    input  wire amigaBusPkg::addrT addr,
    input  wire amigaBusPkg::ttT   tt,
    input  wire amigaBusPkg::tmT   tm,
    input  wire logic              ovl,
    output amigaBusPkg::decodeT    regionSel
);

    ////////////////////
    // Address space and access type
    ////////////////////

    // All motherboard resources sit in the low 16 MB Zorro II window
    logic z2Space;

    // Data or code access in user or supervisor space
    logic eitherAccess;

    // Data access only, which keeps MMU table searches and cache pushes out
    logic dataAccess;

    logic lowRom;
    logic highRom;
    logic ciaSpace;
    logic registerSpace;
    logic rangerSpace;

    assign z2Space      = (addr[31:24] == 8'h00);
    assign eitherAccess = (tm[1] != tm[0]);
    assign dataAccess   = (tm == 2'b01);

    ////////////////////
    // Kickstart ROM
    ////////////////////

    // The reset vector at address 0 reads from ROM while the overlay is set
    assign lowRom  = (addr[23:21] == 3'b000) && ovl;

    // Kickstart runs from $F80000 up, so the overlay does not matter there
    assign highRom = (addr[23:19] == 5'b11111);

    assign regionSel.rom = z2Space && eitherAccess && (lowRom || highRom);

    ////////////////////
    // CIAs
    ////////////////////

    // Both CIAs share the $BFxxxx page and are told apart by A12 and A13
    assign ciaSpace = z2Space && dataAccess && (addr[23:16] == 8'hBF);

    // A12 low selects CIA-A and A13 low selects CIA-B
    // With both low the two chips answer together
    assign regionSel.ciaA = ciaSpace && !addr[12];
    assign regionSel.ciaB = ciaSpace && !addr[13];

    ////////////////////
    // Agnus spaces
    ////////////////////

    // Chip RAM appears at address 0 once Kickstart has dropped the overlay
    assign regionSel.chipRam = z2Space && eitherAccess && !ovl
                             && (addr[23:21] == 3'b000);

    // Custom chip registers at $DFxxxx
    assign registerSpace = (addr[23:16] == 8'hDF);

    // Registers are mirrored into the old Ranger RAM area at $C00000
    // for software that probes there
    assign rangerSpace = (addr[23:19] == 5'b11000);

    assign regionSel.chipReg = z2Space && dataAccess && (registerSpace || rangerSpace);

    ////////////////////
    // Autovector
    ////////////////////

    // Every interrupt is serviced by autovectoring, so an acknowledge in the
    // CPU space at $FFFFxxxx is flagged regardless of transfer modifier
    assign regionSel.autovector = (tt == 2'b11) && (addr[31:16] == 16'hFFFF);

    // The cycle controller relies on a single terminating region, only the
    // CIA pair may overlap
    assert property (@(regionSel)
        $onehot0({regionSel.rom, regionSel.chipRam, regionSel.chipReg,
                  regionSel.autovector}))
        else $error("addressDecode selected more than one exclusive region");

endmodule

`default_nettype wire

//--- hdl/overlayControl.sv
////////////////////
// ROM overlay register
// Set by reset so the CPU boots from Kickstart at address 0, cleared by
// software through a write to the CIA-A overlay register
////////////////////

`timescale 1ns/1ps
`default_nettype none

module overlayControl (
    input  wire logic              bClk,
    input  wire logic              rstN,
    input  wire logic              ciaWriteDone,
    input  wire amigaBusPkg::byteT dataLow,
    output logic                   ovl
);

    ////////////////////
    // Overlay flag
    ////////////////////

    // The flag only ever falls outside reset
    // Kickstart clears it once it runs from high ROM and never sets it again,
    // so a write with bit 0 high is simply ignored
    always_ff @(posedge bClk or negedge rstN) begin
        if (!rstN) begin
            ovl <= 1'b1;
        end else if (ciaWriteDone && !dataLow[0]) begin
            // The written byte is still on the bus in the cycle that ends the write
            ovl <= 1'b0;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Chip RAM can only disappear from address 0 again through a reset,
    // the decoder and the chip RAM contents depend on that
    assert property (@(posedge bClk) disable iff (!rstN)
        !$rose(ovl))
        else $error("overlay rose without a reset");

endmodule

`default_nettype wire

//--- hdl/cycleControl.sv
////////////////////
// Bus cycle controller
// Latches the decode on a transfer start, holds the region strobes for
// the length of the cycle and ends it with a one-cycle ta or tea
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "amigaBus_settings.svh"

module cycleControl (
    input  wire logic                bClk,
    input  wire logic                rstN,
    input  wire logic                ts,
    input  wire logic                rw,
    input  wire amigaBusPkg::addrT   addr,
    input  wire amigaBusPkg::decodeT regionSel,
    input  wire logic                agnusTa,
    output logic                     romCsN,
    output logic                     ciaCs0N,
    output logic                     ciaCs1N,
    output logic                     ramSpaceN,
    output logic                     regSpaceN,
    output logic                     autovector,
    output logic                     ta,
    output logic                     tea,
    output logic                     ciaWriteDone
);

    amigaBusPkg::cycleStateT state;
    amigaBusPkg::decodeT     selQ;
    amigaBusPkg::waitCntT    waitCnt;
    amigaBusPkg::waitCntT    startWait;

    // Set for a CIA-A write to the overlay register, reported when it ends
    logic ovlWriteQ;

    logic ovlWrite;
    logic agnusRegion;
    logic errorCycle;
    logic busy;

    ////////////////////
    // Start of cycle
    ////////////////////

    // R/W high is a read on the 68040, so a write needs rw low
    assign ovlWrite = regionSel.ciaA && !rw
                    && (addr[11:8] == 4'(`OVL_REG_OFFSET));

    // Agnus decides when chip RAM and register accesses are done
    assign agnusRegion = regionSel.chipRam || regionSel.chipReg;

    // Autovector and ROM never overlap the CIAs, and when both CIAs are
    // selected the CIA wait covers the pair
    always_comb begin
        if (regionSel.autovector) begin
            startWait = amigaBusPkg::waitCntT'(`AUTOVECTOR_WAIT);
        end else if (regionSel.rom) begin
            startWait = amigaBusPkg::waitCntT'(`ROM_WAIT);
        end else if (regionSel.ciaA || regionSel.ciaB) begin
            startWait = amigaBusPkg::waitCntT'(`CIA_WAIT);
        end else begin
            startWait = amigaBusPkg::waitCntT'(`ERROR_WAIT);
        end
    end

    // The decode is only sampled on ts, address and attributes are stable
    // for the whole cycle anyway
    always_ff @(posedge bClk) begin
        if (ts && (state == amigaBusPkg::idle)) begin
            selQ      <= regionSel;
            ovlWriteQ <= ovlWrite;
        end
    end

    // Nothing selected means the access is unmapped
    assign errorCycle = (selQ == '0);

    ////////////////////
    // Cycle FSM
    ////////////////////

    always_ff @(posedge bClk or negedge rstN) begin
        if (!rstN) begin
            state        <= amigaBusPkg::idle;
            waitCnt      <= '0;
            ta           <= 1'b0;
            tea          <= 1'b0;
            ciaWriteDone <= 1'b0;
        end else begin
            // Terminations are single-cycle pulses
            ta           <= 1'b0;
            tea          <= 1'b0;
            ciaWriteDone <= 1'b0;
            case (state)
                amigaBusPkg::idle: begin
                    if (ts) begin
                        if (agnusRegion) begin
                            state <= amigaBusPkg::waitAgnus;
                        end else begin
                            state   <= amigaBusPkg::waitFixed;
                            waitCnt <= startWait;
                        end
                    end
                end
                amigaBusPkg::waitFixed: begin
                    // The count reaches zero wait cycles after the strobes go active
                    if (waitCnt == '0) begin
                        state        <= amigaBusPkg::finish;
                        ta           <= !errorCycle;
                        tea          <= errorCycle;
                        ciaWriteDone <= ovlWriteQ;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                amigaBusPkg::waitAgnus: begin
                    // Agnus holds the cycle as long as it needs
                    if (agnusTa) begin
                        state <= amigaBusPkg::finish;
                        ta    <= 1'b1;
                    end
                end
                amigaBusPkg::finish: begin
                    state <= amigaBusPkg::idle;
                end
                default: begin
                    state <= amigaBusPkg::idle;
                end
            endcase
        end
    end

    ////////////////////
    // Strobes
    ////////////////////

    // Strobes follow the wait states one edge late, so they go active the
    // edge after ts and drop on the edge after the termination pulse
    assign busy = (state == amigaBusPkg::waitFixed) || (state == amigaBusPkg::waitAgnus);

    always_ff @(posedge bClk or negedge rstN) begin
        if (!rstN) begin
            romCsN     <= 1'b1;
            ciaCs0N    <= 1'b1;
            ciaCs1N    <= 1'b1;
            ramSpaceN  <= 1'b1;
            regSpaceN  <= 1'b1;
            autovector <= 1'b0;
        end else begin
            romCsN     <= !(busy && selQ.rom);
            ciaCs0N    <= !(busy && selQ.ciaA);
            ciaCs1N    <= !(busy && selQ.ciaB);
            ramSpaceN  <= !(busy && selQ.chipRam);
            regSpaceN  <= !(busy && selQ.chipReg);
            autovector <= busy && selQ.autovector;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    assert property (@(posedge bClk) disable iff (!rstN)
        !(ta && tea))
        else $error("ta and tea asserted together");

    // The CPU has a single transfer in flight
    assert property (@(posedge bClk) disable iff (!rstN)
        ts |-> (state == amigaBusPkg::idle))
        else $error("transfer start while a cycle is still open");

    assert property (@(posedge bClk) disable iff (!rstN)
        (state == amigaBusPkg::idle)
            |-> (&{romCsN, ciaCs0N, ciaCs1N, ramSpaceN, regSpaceN} && !autovector))
        else $error("region strobe active while idle");

endmodule

`default_nettype wire

//--- hdl/busDecodeTop.sv
////////////////////
// Top level of the bus address decoder and cycle terminator
// Connects the region decoder, the ROM overlay register and the
// cycle controller to the processor and Agnus pins
////////////////////

`timescale 1ns/1ps
`default_nettype none

module busDecodeTop (
    input  wire logic              bClk,
    input  wire logic              rstN,
    input  wire logic              ts,
    input  wire amigaBusPkg::addrT addr,
    input  wire amigaBusPkg::ttT   tt,
    input  wire amigaBusPkg::tmT   tm,
    input  wire logic              rw,
    input  wire amigaBusPkg::byteT dataLow,
    input  wire logic              agnusTa,
    output logic                   romCsN,
    output logic                   ciaCs0N,
    output logic                   ciaCs1N,
    output logic                   ramSpaceN,
    output logic                   regSpaceN,
    output logic                   autovector,
    output logic                   ta,
    output logic                   tea
);

    amigaBusPkg::decodeT regionSel;
    logic                ovl;
    logic                ciaWriteDone;

    // Region flags straight from the pins
    addressDecode addressDecode0 (
        .addr      (addr),
        .tt        (tt),
        .tm        (tm),
        .ovl       (ovl),
        .regionSel (regionSel)
    );

    // Overlay follows completed writes to the CIA-A register
    overlayControl overlayControl0 (
        .bClk         (bClk),
        .rstN         (rstN),
        .ciaWriteDone (ciaWriteDone),
        .dataLow      (dataLow),
        .ovl          (ovl)
    );

    cycleControl cycleControl0 (
        .bClk         (bClk),
        .rstN         (rstN),
        .ts           (ts),
        .rw           (rw),
        .addr         (addr),
        .regionSel    (regionSel),
        .agnusTa      (agnusTa),
        .romCsN       (romCsN),
        .ciaCs0N      (ciaCs0N),
        .ciaCs1N      (ciaCs1N),
        .ramSpaceN    (ramSpaceN),
        .regSpaceN    (regSpaceN),
        .autovector   (autovector),
        .ta           (ta),
        .tea          (tea),
        .ciaWriteDone (ciaWriteDone)
    );

endmodule

`default_nettype wire

//--- verif/tbClockGen.sv
////////////////////
// Testbench clock and reset source
// 10 ns bus clock, reset held low for the first four rising edges
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
    output logic bClk,
    output logic rstN
);

    initial begin
        bClk = 1'b0;
        forever #5 bClk = ~bClk;
    end

    // Reset covers four rising edges and is released on the fourth
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge bClk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/busDecodeTb.sv
////////////////////
// Testbench of the bus address decoder and cycle terminator
// Runs directed and random bus cycles from a fixed seed, answers Agnus
// cycles with a delayed agnusTa and checks strobes and terminations
// against a region model with its own overlay flag
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "amigaBus_settings.svh"

module busDecodeTb;

    // 60 bus cycles at most, none longer than 10 clocks
    localparam int cycleLimit = 60 * 10;

    // Clocks to wait for ta or tea before a cycle counts as hung
    localparam int endLimit = 12;

    logic                bClk;
    logic                rstN;
    logic                ts;
    amigaBusPkg::addrT   addr;
    amigaBusPkg::ttT     tt;
    amigaBusPkg::tmT     tm;
    logic                rw;
    amigaBusPkg::byteT   dataLow;
    logic                agnusTa;
    logic                romCsN;
    logic                ciaCs0N;
    logic                ciaCs1N;
    logic                ramSpaceN;
    logic                regSpaceN;
    logic                autovector;
    logic                ta;
    logic                tea;

    integer seed;
    int     errorCount;
    int     testCount;
    int     failedTests;
    int     clockCount;
    int     testStart;

    // Overlay flag as the model tracks it
    logic modelOvl;

    // What the last cycle showed on its first strobe clock, and when it ended
    amigaBusPkg::decodeT seenSel;
    int                  lastEnd;
    int                  lastDelay;
    logic                lastTea;

    string       pinNames [6] = '{"romCsN", "ciaCs0N", "ciaCs1N", "ramSpaceN",
                                  "regSpaceN", "autovector"};
    logic [31:0] agnusAddrs [4] = '{32'h00DF_F09A, 32'h00C0_1234, 32'h0001_2340,
                                    32'h001F_FFFE};

    tbClockGen clockGen0 (
        .bClk (bClk),
        .rstN (rstN)
    );

    busDecodeTop dut0 (
        .bClk       (bClk),
        .rstN       (rstN),
        .ts         (ts),
        .addr       (addr),
        .tt         (tt),
        .tm         (tm),
        .rw         (rw),
        .dataLow    (dataLow),
        .agnusTa    (agnusTa),
        .romCsN     (romCsN),
        .ciaCs0N    (ciaCs0N),
        .ciaCs1N    (ciaCs1N),
        .ramSpaceN  (ramSpaceN),
        .regSpaceN  (regSpaceN),
        .autovector (autovector),
        .ta         (ta),
        .tea        (tea)
    );

    ////////////////////
    // Region model
    ////////////////////

    // Byte address in, region flags out, straight from the memory map
    function automatic amigaBusPkg::decodeT modelDecode(
        input logic [31:0] a,
        input logic [1:0]  t,
        input logic [1:0]  m,
        input logic        o
    );
        amigaBusPkg::decodeT sel;
        logic                z2;
        logic                dataAcc;
        logic                eitherAcc;
        z2 = (a[31:24] == 8'h00);
        dataAcc = (m == 2'd1);
        eitherAcc = (m == 2'd1) || (m == 2'd2);
        sel = '0;
        sel.rom = z2 && eitherAcc && (((a[23:21] == 3'd0) && o) || (a[23:19] == 5'b11111));
        sel.ciaA = z2 && dataAcc && (a[23:16] == 8'hBF) && !a[12];
        sel.ciaB = z2 && dataAcc && (a[23:16] == 8'hBF) && !a[13];
        sel.chipRam = z2 && eitherAcc && (a[23:21] == 3'd0) && !o;
        sel.chipReg = z2 && dataAcc && ((a[23:16] == 8'hDF) || (a[23:19] == 5'b11000));
        // Interrupt acknowledges live in CPU space, outside the z2 window
        sel.autovector = (t == 2'd3) && (a[31:16] == 16'hFFFF);
        return sel;
    endfunction

    // Clocks from transfer start to ta or tea for a region with a fixed wait
    function automatic int fixedEnd(input amigaBusPkg::decodeT sel);
        int cycles;
        if (sel.autovector) begin
            cycles = `AUTOVECTOR_WAIT + 1;
        end else if (sel.rom) begin
            cycles = `ROM_WAIT + 1;
        end else if (sel.ciaA || sel.ciaB) begin
            cycles = `CIA_WAIT + 1;
        end else begin
            cycles = `ERROR_WAIT + 1;
        end
        return cycles;
    endfunction

    ////////////////////
    // Checks and reports
    ////////////////////

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        errorCount++;
    endtask

    // Compares all six select pins with the regions that should be driven
    task automatic checkPins(input amigaBusPkg::decodeT exp);
        logic [5:0] gotPins;
        logic [5:0] expPins;
        gotPins = {romCsN, ciaCs0N, ciaCs1N, ramSpaceN, regSpaceN, autovector};
        expPins = {!exp.rom, !exp.ciaA, !exp.ciaB, !exp.chipRam, !exp.chipReg,
                   exp.autovector};
        for (int i = 0; i < 6; i++) begin
            if (gotPins[5 - i] !== expPins[5 - i]) begin
                reportValue(pinNames[i], 32'(gotPins[5 - i]), 32'(expPins[5 - i]));
            end
        end
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("%s: ok", name);
        end else begin
            failedTests++;
            $display("%s: FAILED with %0d errors", name, errorCount - startErrors);
        end
    endtask

    ////////////////////
    // Bus cycles
    ////////////////////

    // One full transfer, with Agnus answering after a random delay
    task automatic runCycle(
        input logic [31:0] byteAddr,
        input logic [1:0]  cycTt,
        input logic [1:0]  cycTm,
        input logic        cycRw,
        input logic [7:0]  cycData
    );
        amigaBusPkg::decodeT expSel;
        logic                agnusCycle;
        logic                expTea;
        int                  expEnd;
        int                  delay;
        int                  n;
        expSel = modelDecode(byteAddr, cycTt, cycTm, modelOvl);
        agnusCycle = expSel.chipRam || expSel.chipReg;
        expTea = (expSel == '0);
        delay = $unsigned($random(seed)) % 8;
        expEnd = agnusCycle ? delay + 1 : fixedEnd(expSel);
        lastEnd = -1;
        lastDelay = delay;
        seenSel = '0;

        @(posedge bClk);
        ts <= 1'b1;
        addr <= byteAddr[31:1];
        tt <= cycTt;
        tm <= cycTm;
        rw <= cycRw;
        dataLow <= cycData;

        // Clock n counts edges from the one that samples ts
        n = 0;
        while (lastEnd < 0 && n <= endLimit) begin
            @(posedge bClk);
            if (n == 0) ts <= 1'b0;
            // Agnus raises its done level delay clocks into the access
            if (agnusCycle && n == delay) agnusTa <= 1'b1;
            @(negedge bClk);
            if (n == 0) checkPins('0);
            else checkPins(expSel);
            if (n == 1) seenSel = {!romCsN, !ciaCs0N, !ciaCs1N, !ramSpaceN, !regSpaceN,
                                   autovector};
            if (ta || tea) begin
                lastEnd = n;
                lastTea = tea;
                if (ta !== !expTea) reportValue("ta", 32'(ta), 32'(!expTea));
                if (tea !== expTea) reportValue("tea", 32'(tea), 32'(expTea));
            end
            n++;
        end

        if (lastEnd < 0) begin
            $display("Cycle at address %08h got no ta or tea within %0d clocks", byteAddr,
                     endLimit);
            errorCount++;
        end else begin
            if (lastEnd != expEnd) reportValue("ta/tea clock", 32'(lastEnd), 32'(expEnd));
            @(posedge bClk);
            agnusTa <= 1'b0;
            // Strobes drop on the edge after the termination pulse
            @(negedge bClk);
            checkPins('0);
            if (ta !== 1'b0) reportValue("ta", 32'(ta), 32'd0);
            if (tea !== 1'b0) reportValue("tea", 32'(tea), 32'd0);
        end

        // A finished CIA-A overlay register write with bit 0 low maps chip RAM at 0
        if (expSel.ciaA && !cycRw && (byteAddr[11:8] == 4'(`OVL_REG_OFFSET))
            && !cycData[0]) modelOvl = 1'b0;
    endtask

    // Random cycle, weighted toward ROM, CIA, Agnus and CPU space
    task automatic randomCycle();
        logic [31:0] word;
        logic [31:0] a;
        logic [1:0]  t;
        logic [1:0]  m;
        int          kind;
        word = $random(seed);
        kind = $unsigned($random(seed)) % 8;
        case (kind)
            0: a = {13'h001F, word[18:0]};
            1: a = {11'h000, word[20:0]};
            2: a = {16'h00BF, word[15:0]};
            3: a = {16'h00DF, word[15:0]};
            4: a = {13'h0018, word[18:0]};
            5: a = {16'hFFFF, word[15:0]};
            default: a = word;
        endcase
        word = $random(seed);
        t = (kind == 5 && word[0]) ? 2'd3 : word[4:3];
        // Mostly data accesses, sometimes any modifier
        m = (word[6:5] == 2'd0) ? word[8:7] : 2'd1;
        runCycle(a, t, m, word[9], word[17:10]);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        ts = 1'b0;
        addr = '0;
        tt = '0;
        tm = '0;
        rw = 1'b1;
        dataLow = '0;
        agnusTa = 1'b0;
        seed = 40805;
        errorCount = 0;
        testCount = 0;
        failedTests = 0;
        modelOvl = 1'b1;
        wait (rstN === 1'b1);
        @(negedge bClk);

        // Idle outputs after reset, then the reset vector fetch from ROM
        testStart = errorCount;
        checkPins('0);
        if (ta !== 1'b0) reportValue("ta", 32'(ta), 32'd0);
        if (tea !== 1'b0) reportValue("tea", 32'(tea), 32'd0);
        runCycle(32'h0000_0000, 2'd0, 2'd1, 1'b1, 8'h00);
        if (seenSel.rom !== 1'b1) reportValue("romCsN", 32'(!seenSel.rom), 32'd0);
        if (lastEnd != `ROM_WAIT + 1) reportValue("ta clock", 32'(lastEnd), `ROM_WAIT + 1);
        finishTest("reset and ROM read", testStart);

        // A12 picks CIA-A, A13 picks CIA-B, both low selects both
        testStart = errorCount;
        runCycle(32'h00BF_E001, 2'd0, 2'd1, 1'b1, 8'h00);
        if ({!seenSel.ciaA, !seenSel.ciaB} !== 2'b01)
            reportValue("ciaCs0N/ciaCs1N", 32'({!seenSel.ciaA, !seenSel.ciaB}), 32'b01);
        runCycle(32'h00BF_D000, 2'd0, 2'd1, 1'b1, 8'h00);
        if ({!seenSel.ciaA, !seenSel.ciaB} !== 2'b10)
            reportValue("ciaCs0N/ciaCs1N", 32'({!seenSel.ciaA, !seenSel.ciaB}), 32'b10);
        runCycle(32'h00BF_C000, 2'd0, 2'd1, 1'b1, 8'h00);
        if ({!seenSel.ciaA, !seenSel.ciaB} !== 2'b00)
            reportValue("ciaCs0N/ciaCs1N", 32'({!seenSel.ciaA, !seenSel.ciaB}), 32'b00);
        finishTest("CIA selects", testStart);

        // Bit 0 high keeps the overlay, bit 0 low drops it for good
        testStart = errorCount;
        runCycle(32'h00BF_E001, 2'd0, 2'd1, 1'b0, 8'h01);
        runCycle(32'h0000_0000, 2'd0, 2'd1, 1'b1, 8'h00);
        if (seenSel.rom !== 1'b1) reportValue("romCsN", 32'(!seenSel.rom), 32'd0);
        runCycle(32'h00BF_E001, 2'd0, 2'd1, 1'b0, 8'hFE);
        runCycle(32'h0000_0000, 2'd0, 2'd1, 1'b1, 8'h00);
        if ({!seenSel.rom, !seenSel.chipRam} !== 2'b10)
            reportValue("romCsN/ramSpaceN", 32'({!seenSel.rom, !seenSel.chipRam}), 32'b10);
        finishTest("ROM overlay", testStart);

        // Register space, Ranger mirror and chip RAM, all ended by Agnus
        testStart = errorCount;
        for (int i = 0; i < 4; i++) begin
            runCycle(agnusAddrs[i], 2'd0, (i == 3) ? 2'd2 : 2'd1, (i % 2) == 0, 8'h5A);
            if ((seenSel.chipRam || seenSel.chipReg) !== 1'b1)
                reportValue("ramSpaceN/regSpaceN", 32'({!seenSel.chipRam, !seenSel.chipReg}),
                            32'b01);
            if (lastEnd != lastDelay + 1)
                reportValue("agnusTa to ta clocks", 32'(lastEnd - lastDelay), 32'd1);
        end
        finishTest("Agnus cycles", testStart);

        // Holes in the map and MMU searches end in tea, autovector ignores tm
        testStart = errorCount;
        runCycle(32'h00A0_0000, 2'd0, 2'd1, 1'b1, 8'h00);
        if (lastTea !== 1'b1) reportValue("tea", 32'(lastTea), 32'd1);
        runCycle(32'h00F8_0000, 2'd0, 2'd0, 1'b1, 8'h00);
        if (seenSel !== '0) reportValue("strobes", {26'd0, seenSel}, 32'd0);
        runCycle(32'h00DF_F000, 2'd0, 2'd3, 1'b0, 8'h00);
        if (lastEnd != `ERROR_WAIT + 1) reportValue("tea clock", 32'(lastEnd), `ERROR_WAIT + 1);
        runCycle(32'hFFFF_FFF0, 2'd3, 2'd0, 1'b1, 8'h00);
        if (seenSel.autovector !== 1'b1) reportValue("autovector", 32'(seenSel.autovector), 1);
        finishTest("unmapped and autovector", testStart);

        testStart = errorCount;
        repeat (40) randomCycle();
        finishTest("random cycles", testStart);

        $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Hard stop in case the DUT stalls the sequence
    initial begin
        clockCount = 0;
        while (clockCount < cycleLimit) begin
            @(posedge bClk);
            clockCount++;
        end
        $display("Run stopped after %0d clocks before all tests finished", cycleLimit);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/amigaBusPkg.sv
hdl/addressDecode.sv
hdl/overlayControl.sv
hdl/cycleControl.sv
hdl/busDecodeTop.sv
verif/tbClockGen.sv
verif/busDecodeTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= busDecodeTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
